//--- rtl/ntt_addr_seq.sv
/*
 * Walks all wide addresses once per start, no back-pressure.
 * A new run needs run_en to drop low after the previous one.
 */
`default_nettype none

`include "ntt_consts.svh"

module ntt_addr_seq (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    run_en,
    input  wire                    masked,
    output ntt_pkg::rd_req_t       rd_req
);

    logic                    busy;
    logic                    hold;
    logic [`NTT_WADDR_W-1:0] waddr;
    logic [`NTT_WADDR_W-1:0] end_addr;
    logic                    at_end;

    // Last wide address depends on the word view
    assign end_addr = masked ? `NTT_WADDR_W'(`NTT_MSK_WORDS - 1)
                             : `NTT_WADDR_W'(`NTT_UNM_WORDS - 1);
    assign at_end   = (waddr == end_addr);

    // ============================================================
    // Idle/busy control and address counter
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            hold  <= 1'b0;
            waddr <= '0;
        end else if (busy) begin
            if (at_end) begin
                busy  <= 1'b0;
                hold  <= 1'b1;
                waddr <= '0;
            end else begin
                waddr <= waddr + 1'b1;
            end
        end else begin
            // ENABLE stays high until done comes back, so wait for it to fall
            if (!run_en) begin
                hold <= 1'b0;
            end else if (!hold) begin
                busy  <= 1'b1;
                waddr <= '0;
            end
        end
    end

    always_comb begin
        rd_req.valid = busy;
        rd_req.waddr = waddr;
        rd_req.last  = busy & at_end;
    end

endmodule

`default_nettype wire

//--- rtl/ntt_consts.svh
/*
 * Modulus, widths, depths and register map of the coefficient store.
 * Register addresses sit at the top of the 9-bit bus space.
 */
`ifndef NTT_CONSTS_SVH
`define NTT_CONSTS_SVH

// ============================================================
// Arithmetic
// ============================================================
`define NTT_Q            24'd8380417
`define NTT_COEF_W       24
`define NTT_MCOEF_W      48

// ============================================================
// Bus and engine geometry
// ============================================================
`define NTT_ADDR_W       9
`define NTT_BUS_W        64
`define NTT_WIDE_W       384
`define NTT_WADDR_W      6
`define NTT_UNM_WORDS    64
`define NTT_MSK_WORDS    32

// Control words
`define NTT_STATUS_REG   9'd511
`define NTT_ENABLE_REG   9'd510
`define NTT_CTRL_REG     9'd509
`define NTT_SCALE_REG    9'd508
`define NTT_CTRL_MASK_BIT 0

`endif

//--- rtl/ntt_mod_scale.sv
/*
 * Two-cycle scaler, lane times scale mod q, for any 24-bit inputs.
 * Reduction folds 2^23 = 2^13 - 1 mod q three times, then one subtract.
 */
`default_nettype none

`include "ntt_consts.svh"

module ntt_mod_scale (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire ntt_pkg::wr_req_t  rd_rsp,
    input  wire                    masked,
    input  wire ntt_pkg::coef_t    scale,
    output ntt_pkg::wr_req_t       wr_req,
    output logic                   done
);
    import ntt_pkg::*;

    // 16 operand slots, one per share, unmasked mode uses the first 4
    coef_t                     op [16];
    logic [`NTT_MCOEF_W-1:0]   s1_prod [16];
    logic                      s1_valid;
    logic [`NTT_WADDR_W-1:0]   s1_waddr;
    logic                      s1_last;
    ntt_word_u                 s2_word;
    logic                      wb_valid;
    logic [`NTT_WADDR_W-1:0]   wb_waddr;
    logic                      wb_last;
    ntt_word_u                 wb_data;

    function automatic coef_t mod_q(input logic [`NTT_MCOEF_W-1:0] x);
        logic [38:0] y;
        logic [29:0] z;
        logic [23:0] w;
        y = (39'(x[47:23]) << 13) - 39'(x[47:23]) + 39'(x[22:0]);
        z = (30'(y[38:23]) << 13) - 30'(y[38:23]) + 30'(y[22:0]);
        w = (24'(z[29:23]) << 13) - 24'(z[29:23]) + 24'(z[22:0]);
        // w is below 2q here
        return (w >= `NTT_Q) ? w - `NTT_Q : w;
    endfunction

    // ============================================================
    // Stage one, products
    // ============================================================
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            if (masked) begin
                op[i] = (i % 2 == 1) ? rd_rsp.data.msk[i/2].hi : rd_rsp.data.msk[i/2].lo;
            end else if (i < 4) begin
                op[i] = rd_rsp.data.unm.lane[i];
            end else begin
                op[i] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s1_waddr <= '0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= rd_rsp.valid;
            s1_waddr <= rd_rsp.waddr;
            s1_last  <= rd_rsp.valid & rd_rsp.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_rsp.valid) begin
            for (int i = 0; i < 16; i++) begin
                s1_prod[i] <= `NTT_MCOEF_W'(op[i]) * `NTT_MCOEF_W'(scale);
            end
        end
    end

    // ============================================================
    // Stage two, reduce and repack in the same view
    // ============================================================
    always_comb begin
        s2_word = '0;
        if (masked) begin
            for (int i = 0; i < 8; i++) begin
                s2_word.msk[i].lo = mod_q(s1_prod[2*i]);
                s2_word.msk[i].hi = mod_q(s1_prod[2*i+1]);
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                s2_word.unm.lane[i] = mod_q(s1_prod[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid <= 1'b0;
            wb_waddr <= '0;
            wb_last  <= 1'b0;
            done     <= 1'b0;
        end else begin
            wb_valid <= s1_valid;
            wb_waddr <= s1_waddr;
            wb_last  <= s1_last;
            done     <= s1_valid & s1_last;   // same cycle as the last write-back
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            wb_data <= s2_word;
        end
    end

    always_comb begin
        wr_req.valid = wb_valid;
        wr_req.waddr = wb_waddr;
        wr_req.last  = wb_last;
        wr_req.data  = wb_data;
    end

endmodule

`default_nettype wire

//--- rtl/ntt_pkg.sv
/*
 * Coefficient and wide-word types shared by the engine and the store.
 * Lane 0 of either view sits at the least significant end of the word.
 */
`default_nettype none

`include "ntt_consts.svh"

package ntt_pkg;

    // One coefficient, or one share of a masked coefficient
    typedef logic [`NTT_COEF_W-1:0] coef_t;

    // Masked coefficient, low share in the low bits of the slot
    typedef struct packed {
        coef_t hi;
        coef_t lo;
    } mcoef_t;

    // Unmasked wide word, 4 lanes with the upper bits unused
    typedef struct packed {
        logic [`NTT_WIDE_W-4*`NTT_COEF_W-1:0] pad;
        coef_t [3:0]                          lane;
    } unm_word_t;

    // ============================================================
    // Wide engine word, decoded by CTRL mask bit
    // ============================================================
    typedef union packed {
        unm_word_t   unm;
        mcoef_t [7:0] msk;
    } ntt_word_u;

    // Wide read request from the sequencer
    typedef struct packed {
        logic                    valid;
        logic [`NTT_WADDR_W-1:0] waddr;
        logic                    last;
    } rd_req_t;

    // Tagged wide word, read data or write-back
    typedef struct packed {
        logic                    valid;
        logic [`NTT_WADDR_W-1:0] waddr;
        logic                    last;
        ntt_word_u               data;
    } wr_req_t;

endpackage

`default_nettype wire

//--- rtl/ntt_special_mem.sv
/*
 * Bus writes win over engine write-back in the same cycle; the latter is lost.
 * Slots 0-255 hold coefficients, 508-511 are SCALE, CTRL, ENABLE and STATUS.
 * CTRL mask bit must stay stable while the engine runs.
 */
`default_nettype none

`include "ntt_consts.svh"

module ntt_special_mem (
    input  wire                    clk,
    input  wire                    reset_n,
    // Register bus
    input  wire                    bus_en,
    input  wire                    bus_we,
    input  wire [`NTT_ADDR_W-1:0]  bus_addr,
    input  wire [`NTT_BUS_W-1:0]   bus_wdata,
    output logic [`NTT_BUS_W-1:0]  bus_rdata,
    // Engine ports
    input  wire ntt_pkg::rd_req_t  rd_req,
    output ntt_pkg::wr_req_t       rd_rsp,
    input  wire ntt_pkg::wr_req_t  wr_req,
    input  wire                    done,
    // Control levels to the engine
    output logic                   run_en,
    output logic                   masked,
    output ntt_pkg::coef_t         scale
);
    import ntt_pkg::*;

    logic [`NTT_BUS_W-1:0]   mem [2**`NTT_ADDR_W];
    logic [`NTT_BUS_W-1:0]   status_reg;
    logic [`NTT_BUS_W-1:0]   enable_reg;
    logic [`NTT_BUS_W-1:0]   ctrl_reg;
    logic [`NTT_BUS_W-1:0]   bus_rd_word;
    ntt_word_u               rd_word;
    logic                    rsp_valid;
    logic [`NTT_WADDR_W-1:0] rsp_waddr;
    logic                    rsp_last;
    ntt_word_u               rsp_data;

    assign run_en = enable_reg[0];
    assign masked = ctrl_reg[`NTT_CTRL_MASK_BIT];
    assign scale  = mem[`NTT_SCALE_REG][`NTT_COEF_W-1:0];

    // ============================================================
    // Bus read port
    // ============================================================
    always_comb begin
        case (bus_addr)
            `NTT_STATUS_REG: bus_rd_word = status_reg;
            `NTT_ENABLE_REG: bus_rd_word = enable_reg;
            `NTT_CTRL_REG:   bus_rd_word = ctrl_reg;
            default:         bus_rd_word = mem[bus_addr];
        endcase
    end

    // Zero when no read was requested
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus_rdata <= '0;
        end else begin
            bus_rdata <= bus_en ? bus_rd_word : '0;
        end
    end

    // ============================================================
    // Wide read port, gathers 4 or 8 slots
    // ============================================================
    always_comb begin
        rd_word = '0;
        if (masked) begin
            for (int i = 0; i < 8; i++) begin
                rd_word.msk[i] = mem[{1'b0, rd_req.waddr[4:0], 3'(i)}][`NTT_MCOEF_W-1:0];
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                rd_word.unm.lane[i] = mem[{1'b0, rd_req.waddr, 2'(i)}][`NTT_COEF_W-1:0];
            end
        end
    end

    // Tags follow the request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_valid <= 1'b0;
            rsp_waddr <= '0;
            rsp_last  <= 1'b0;
        end else begin
            rsp_valid <= rd_req.valid;
            rsp_waddr <= rd_req.waddr;
            rsp_last  <= rd_req.valid & rd_req.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req.valid) begin
            rsp_data <= rd_word;
        end
    end

    always_comb begin
        rd_rsp.valid = rsp_valid;
        rd_rsp.waddr = rsp_waddr;
        rd_rsp.last  = rsp_last;
        rd_rsp.data  = rsp_data;
    end

    // ============================================================
    // Slot writes, bus first then engine write-back
    // ============================================================
    always_ff @(posedge clk) begin
        if (bus_we) begin
            mem[bus_addr] <= bus_wdata;
        end else if (wr_req.valid) begin
            if (masked) begin
                for (int i = 0; i < 8; i++) begin
                    mem[{1'b0, wr_req.waddr[4:0], 3'(i)}] <= `NTT_BUS_W'(wr_req.data.msk[i]);
                end
            end else begin
                for (int i = 0; i < 4; i++) begin
                    mem[{1'b0, wr_req.waddr, 2'(i)}] <= `NTT_BUS_W'(wr_req.data.unm.lane[i]);
                end
            end
        end
    end

    // Control words and their side effects
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            status_reg <= '0;
            enable_reg <= '0;
            ctrl_reg   <= '0;
        end else if (bus_we) begin
            case (bus_addr)
                `NTT_STATUS_REG: status_reg <= bus_wdata;
                `NTT_ENABLE_REG: begin
                    enable_reg <= bus_wdata;
                    // New start clears the previous done
                    if (bus_wdata[0]) begin
                        status_reg <= '0;
                    end
                end
                `NTT_CTRL_REG:   ctrl_reg <= bus_wdata;
                default: ;
            endcase
        end else if (done) begin
            status_reg <= `NTT_BUS_W'(1);
            enable_reg <= '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ntt_subsys_top.sv
/*
 * Coefficient store with its scaling engine behind a 64-bit register bus.
 * Software writes ENABLE bit 0 to start, then polls STATUS.
 */
`default_nettype none

`include "ntt_consts.svh"

module ntt_subsys_top (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    bus_en,
    input  wire                    bus_we,
    input  wire [`NTT_ADDR_W-1:0]  bus_addr,
    input  wire [`NTT_BUS_W-1:0]   bus_wdata,
    output logic [`NTT_BUS_W-1:0]  bus_rdata
);
    import ntt_pkg::*;

    rd_req_t rd_req;
    wr_req_t rd_rsp;
    wr_req_t wr_req;
    logic    done;
    logic    run_en;
    logic    masked;
    coef_t   scale;

    // Store and control registers
    ntt_special_mem u_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .bus_en    (bus_en),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .wr_req    (wr_req),
        .done      (done),
        .run_en    (run_en),
        .masked    (masked),
        .scale     (scale)
    );

    ntt_addr_seq u_seq (
        .clk     (clk),
        .reset_n (reset_n),
        .run_en  (run_en),
        .masked  (masked),
        .rd_req  (rd_req)
    );

    // Write-back path
    ntt_mod_scale u_scale (
        .clk     (clk),
        .reset_n (reset_n),
        .rd_rsp  (rd_rsp),
        .masked  (masked),
        .scale   (scale),
        .wr_req  (wr_req),
        .done    (done)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
# Result is decided by searching sim.log for the failure line.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    -f tb.f \
    --top-module tb_ntt_subsys \
    -o tb_ntt_subsys

./obj_dir/tb_ntt_subsys | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- tb.f
+incdir+rtl
rtl/ntt_pkg.sv
rtl/ntt_special_mem.sv
rtl/ntt_addr_seq.sv
rtl/ntt_mod_scale.sv
rtl/ntt_subsys_top.sv
verif/tb_ntt_subsys.sv

//--- verif/tb_ntt_subsys.sv
/*
 * Directed testbench for the coefficient store and its scaling engine.
 * Bus inputs change 1 ns after the rising edge; results are polled via STATUS.
 * The second-enable test reuses the data left by the unmasked run.
 */
`default_nettype none

`include "ntt_consts.svh"

module tb_ntt_subsys;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 6000;
    localparam logic [63:0] Q              = 64'(`NTT_Q);

    logic                   clk;
    logic                   reset_n;
    logic                   bus_en;
    logic                   bus_we;
    logic [`NTT_ADDR_W-1:0] bus_addr;
    logic [`NTT_BUS_W-1:0]  bus_wdata;
    logic [`NTT_BUS_W-1:0]  bus_rdata;

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          cycle_count;
    logic [63:0] ref_slot [256];
    logic [63:0] scalar;

    ntt_subsys_top UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .bus_en    (bus_en),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata)
    );

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] random_word();
        logic [31:0] hi_part;
        logic [31:0] lo_part;
        hi_part = next_random();
        lo_part = next_random();
        return {hi_part, lo_part};
    endfunction

    // Operands below q keep the product within 64 bits
    function automatic logic [63:0] mul_mod_q(input logic [63:0] a, input logic [63:0] s);
        return (a * s) % Q;
    endfunction

    task automatic check_word(input string test_name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic bus_write(input logic [`NTT_ADDR_W-1:0] addr, input logic [63:0] data);
        bus_we    = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(posedge clk);
        #1;
        bus_we    = 1'b0;
    endtask

    task automatic bus_read(input logic [`NTT_ADDR_W-1:0] addr, output logic [63:0] data);
        bus_en   = 1'b1;
        bus_addr = addr;
        @(posedge clk);
        #1;
        bus_en   = 1'b0;
        data     = bus_rdata;
    endtask

    task automatic wait_status();
        logic [63:0] data;
        data = '0;
        while (data[0] == 1'b0) begin
            bus_read(`NTT_STATUS_REG, data);
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic test_reset_values();
        logic [63:0] data;
        logic [63:0] pattern;
        pattern = 64'ha5a5_5a5a_c3c3_3c3c;
        check_word("reset_values rdata idle", 64'd0, bus_rdata);
        bus_read(`NTT_STATUS_REG, data);
        check_word("reset_values STATUS", 64'd0, data);
        bus_read(`NTT_ENABLE_REG, data);
        check_word("reset_values ENABLE", 64'd0, data);
        bus_read(`NTT_CTRL_REG, data);
        check_word("reset_values CTRL", 64'd0, data);
        // Nonzero word on the read bus first
        bus_write(`NTT_ADDR_W'(0), pattern);
        bus_read(`NTT_ADDR_W'(0), data);
        check_word("reset_values slot 0", pattern, data);
        // One cycle without bus_en
        @(posedge clk);
        #1;
        check_word("reset_values rdata after idle", 64'd0, bus_rdata);
    endtask

    task automatic test_bus_round_trip();
        logic [63:0] words [16];
        logic [63:0] scale_word;
        logic [63:0] data;
        // Stride 17 hits 16 distinct slots
        for (int i = 0; i < 16; i++) begin
            words[i] = random_word();
            bus_write(`NTT_ADDR_W'((i * 17) % 256), words[i]);
        end
        scale_word = random_word();
        bus_write(`NTT_SCALE_REG, scale_word);
        for (int i = 0; i < 16; i++) begin
            bus_read(`NTT_ADDR_W'((i * 17) % 256), data);
            check_word($sformatf("bus_round_trip slot %0d", (i * 17) % 256), words[i], data);
        end
        bus_read(`NTT_SCALE_REG, data);
        check_word("bus_round_trip SCALE", scale_word, data);
    endtask

    task automatic test_unmasked_run();
        logic [63:0] data;
        logic [63:0] junk;
        // Junk in bits 63:24 must come back as zero
        for (int i = 0; i < 256; i++) begin
            ref_slot[i] = 64'(next_random()) % Q;
            junk        = random_word();
            bus_write(`NTT_ADDR_W'(i), {junk[63:24], ref_slot[i][23:0]});
        end
        scalar = (64'(next_random()) % (Q - 64'd1)) + 64'd1;
        bus_write(`NTT_SCALE_REG, scalar);
        bus_write(`NTT_CTRL_REG, 64'd0);
        bus_write(`NTT_ENABLE_REG, 64'd1);
        wait_status();
        bus_read(`NTT_ENABLE_REG, data);
        check_word("unmasked_run ENABLE", 64'd0, data);
        for (int i = 0; i < 256; i++) begin
            ref_slot[i] = mul_mod_q(ref_slot[i], scalar);
            bus_read(`NTT_ADDR_W'(i), data);
            check_word($sformatf("unmasked_run slot %0d", i), ref_slot[i], data);
        end
    endtask

    // Restarts on the data left by the unmasked run
    task automatic test_new_enable();
        logic [63:0] data;
        bus_read(`NTT_STATUS_REG, data);
        check_word("new_enable STATUS before", 64'd1, data);
        bus_write(`NTT_ENABLE_REG, 64'd1);
        bus_read(`NTT_STATUS_REG, data);
        check_word("new_enable STATUS cleared", 64'd0, data);
        wait_status();
        bus_read(`NTT_ENABLE_REG, data);
        check_word("new_enable ENABLE", 64'd0, data);
        for (int i = 0; i < 256; i++) begin
            ref_slot[i] = mul_mod_q(ref_slot[i], scalar);
            bus_read(`NTT_ADDR_W'(i), data);
            check_word($sformatf("new_enable slot %0d", i), ref_slot[i], data);
        end
    endtask

    task automatic test_masked_run();
        logic [63:0] data;
        logic [63:0] expected;
        logic [23:0] hi;
        logic [23:0] lo;
        logic [31:0] top;
        // Junk in bits 63:48 must come back as zero
        for (int i = 0; i < 256; i++) begin
            hi  = 24'(64'(next_random()) % Q);
            lo  = 24'(64'(next_random()) % Q);
            top = next_random();
            ref_slot[i] = {top[15:0], hi, lo};
            bus_write(`NTT_ADDR_W'(i), ref_slot[i]);
        end
        scalar = (64'(next_random()) % (Q - 64'd1)) + 64'd1;
        bus_write(`NTT_SCALE_REG, scalar);
        bus_write(`NTT_CTRL_REG, 64'd1 << `NTT_CTRL_MASK_BIT);
        bus_write(`NTT_ENABLE_REG, 64'd1);
        wait_status();
        bus_read(`NTT_ENABLE_REG, data);
        check_word("masked_run ENABLE", 64'd0, data);
        for (int i = 0; i < 256; i++) begin
            expected = {16'h0,
                        24'(mul_mod_q(64'(ref_slot[i][47:24]), scalar)),
                        24'(mul_mod_q(64'(ref_slot[i][23:0]), scalar))};
            bus_read(`NTT_ADDR_W'(i), data);
            check_word($sformatf("masked_run slot %0d", i), expected, data);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        bus_en      = 1'b0;
        bus_we      = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        lcg_state   = 32'h8f63fdbe;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        test_reset_values();
        test_bus_round_trip();
        test_unmasked_run();
        test_new_enable();
        test_masked_run();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
